// ==== udp_link_settings.svh ====
`ifndef UDP_LINK_SETTINGS_SVH
`define UDP_LINK_SETTINGS_SVH

// Payload carried in every datagram, in both directions
`define UDP_LINK_PAYLOAD_BITS 64

// Top 32 payload bits of a datagram that is accepted
`define UDP_LINK_MSG_ID 32'h7469_7277

// Network setup written during initialization
`define UDP_LINK_MAC_ADDR 48'hAAAF_FACC_E31C
`define UDP_LINK_LOCAL_IP 32'hC0A8_0AC1
`define UDP_LINK_GATEWAY_IP 32'hC0A8_0A01
`define UDP_LINK_SUBNET_MASK 32'hFFFF_FF00
`define UDP_LINK_DST_IP 32'hC0A8_0A0A
`define UDP_LINK_LOCAL_PORT 16'd2390
`define UDP_LINK_DST_PORT 16'd5000

// Idle cycles between two RX size polls
`define UDP_LINK_POLL_INTERVAL 10

// Cycles without an accepted datagram before pkg_timeout rises
`define UDP_LINK_TIMEOUT_CYCLES 4800000

`endif

// ==== udp_link_pkg.sv ====
`include "udp_link_settings.svh"

package udp_link_pkg;

    typedef logic [`UDP_LINK_PAYLOAD_BITS-1:0] payload_t;

    // One W5500 SPI command: address phase, control phase, one data byte
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  ctrl;
        logic [7:0]  data;
    } spi_cmd_t;

    typedef enum logic [1:0] {
        FRAME_CMD,
        FRAME_PUSH,
        FRAME_PULL
    } frame_kind_e;

    typedef struct packed {
        frame_kind_e kind;
        spi_cmd_t    cmd;
    } frame_req_t;

    typedef enum logic [3:0] {
        INIT,
        WAIT_SOCKET,
        IDLE,
        POLL,
        PULL,
        RX_PTR_LO,
        RX_PTR_HI,
        RX_RECV,
        PUSH,
        TX_PTR_LO,
        TX_PTR_HI,
        TX_SEND
    } seq_state_e;

    // Info header that the W5500 puts in front of each UDP datagram
    typedef struct packed {
        logic [31:0] src_ip;
        logic [15:0] src_port;
        logic [15:0] length;
    } rx_header_t;

    localparam int PULL_BITS = $bits(rx_header_t) + $bits(payload_t);

    // Control bytes: block select, read/write, variable length mode
    localparam logic [7:0] CTRL_COMMON_WR = 8'h04;
    localparam logic [7:0] CTRL_S0_WR     = 8'h0C;
    localparam logic [7:0] CTRL_S0_RD     = 8'h08;
    localparam logic [7:0] CTRL_TXBUF_WR  = 8'h14;
    localparam logic [7:0] CTRL_RXBUF_RD  = 8'h18;

    // Sn_SR value once the socket is open in UDP mode
    localparam logic [7:0] SOCK_UDP = 8'h22;

endpackage

// ==== w5500_spi_engine.sv ====
module w5500_spi_engine (
    input  logic                                  clk,
    input  logic                                  reset,
    input  udp_link_pkg::frame_req_t              frame_req,
    input  logic                                  frame_start,
    input  udp_link_pkg::payload_t                tx_data,
    input  logic                                  miso,
    output logic                                  frame_done,
    output logic [7:0]                            read_byte,
    output logic [udp_link_pkg::PULL_BITS-1:0]    pull_bits,
    output logic                                  mosi,
    output logic                                  sclk,
    output logic                                  cs_n
);
    import udp_link_pkg::*;

    localparam int OUT_BITS  = 24 + $bits(payload_t);
    localparam int FRAME_MAX = 24 + PULL_BITS;
    localparam int CNT_W     = $clog2(FRAME_MAX + 1);

    logic                 active;
    logic [CNT_W-1:0]     bits_left;
    logic [CNT_W-1:0]     frame_len;
    logic [OUT_BITS-1:0]  out_load;
    logic [OUT_BITS-1:0]  shift_out;
    logic [PULL_BITS-1:0] shift_in;

    // Frame length and MOSI image follow from the frame kind
    always_comb begin
        out_load = '0;
        case (frame_req.kind)
            FRAME_PUSH: begin
                frame_len = CNT_W'(OUT_BITS);
                out_load  = {frame_req.cmd.addr, frame_req.cmd.ctrl, tx_data};
            end
            FRAME_PULL: begin
                frame_len = CNT_W'(FRAME_MAX);
                out_load[OUT_BITS-1 -: 24] = {frame_req.cmd.addr, frame_req.cmd.ctrl};
            end
            default: begin
                frame_len = CNT_W'(32);
                out_load[OUT_BITS-1 -: 32] = frame_req.cmd;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        frame_done <= 1'b0;
        if (reset) begin
            active    <= 1'b0;
            bits_left <= '0;
            sclk      <= 1'b0;
            cs_n      <= 1'b1;
        end else if (frame_start) begin
            active    <= 1'b1;
            bits_left <= frame_len;
            sclk      <= 1'b0;
            cs_n      <= 1'b0;
        end else if (active) begin
            sclk <= ~sclk;
            // Falling edge closes one bit
            if (sclk) begin
                bits_left <= bits_left - 1'b1;
                if (bits_left == CNT_W'(1)) begin
                    active     <= 1'b0;
                    cs_n       <= 1'b1;
                    frame_done <= 1'b1;
                end
            end
        end
    end

    // MOSI moves on the falling edge, MISO is taken on the rising edge
    always_ff @(posedge clk) begin
        if (frame_start) begin
            shift_out <= out_load;
        end else if (active) begin
            if (sclk) begin
                shift_out <= shift_out << 1;
            end else begin
                shift_in <= {shift_in[PULL_BITS-2:0], miso};
            end
        end
    end

    assign mosi      = shift_out[OUT_BITS-1];
    assign read_byte = shift_in[7:0];
    assign pull_bits = shift_in;

endmodule

// ==== w5500_cmd_sequencer.sv ====
`include "udp_link_settings.svh"

module w5500_cmd_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    output udp_link_pkg::frame_req_t frame_req,
    output logic                     frame_start,
    input  logic                     frame_done,
    input  logic [7:0]               read_byte,
    input  logic                     reply_pending,
    output logic                     reply_taken
);
    import udp_link_pkg::*;

    localparam int INIT_LEN          = 30;
    localparam int POLL_W            = $clog2(`UDP_LINK_POLL_INTERVAL + 1);
    localparam logic [15:0] RX_STEP  = 16'(PULL_BITS / 8);
    localparam logic [15:0] TX_STEP  = 16'($bits(payload_t) / 8);

    localparam logic [47:0] MAC      = `UDP_LINK_MAC_ADDR;
    localparam logic [31:0] LOCAL_IP = `UDP_LINK_LOCAL_IP;
    localparam logic [31:0] GW_IP    = `UDP_LINK_GATEWAY_IP;
    localparam logic [31:0] SUBNET   = `UDP_LINK_SUBNET_MASK;
    localparam logic [31:0] DST_IP   = `UDP_LINK_DST_IP;
    localparam logic [15:0] SRC_PORT = `UDP_LINK_LOCAL_PORT;
    localparam logic [15:0] DST_PORT = `UDP_LINK_DST_PORT;

    localparam spi_cmd_t INIT_TABLE [INIT_LEN] = '{
        // PHY forced to 100M full duplex
        '{16'h002E, CTRL_COMMON_WR, 8'hD8},
        '{16'h0009, CTRL_COMMON_WR, MAC[47:40]},
        '{16'h000A, CTRL_COMMON_WR, MAC[39:32]},
        '{16'h000B, CTRL_COMMON_WR, MAC[31:24]},
        '{16'h000C, CTRL_COMMON_WR, MAC[23:16]},
        '{16'h000D, CTRL_COMMON_WR, MAC[15:8]},
        '{16'h000E, CTRL_COMMON_WR, MAC[7:0]},
        '{16'h000F, CTRL_COMMON_WR, LOCAL_IP[31:24]},
        '{16'h0010, CTRL_COMMON_WR, LOCAL_IP[23:16]},
        '{16'h0011, CTRL_COMMON_WR, LOCAL_IP[15:8]},
        '{16'h0012, CTRL_COMMON_WR, LOCAL_IP[7:0]},
        '{16'h0001, CTRL_COMMON_WR, GW_IP[31:24]},
        '{16'h0002, CTRL_COMMON_WR, GW_IP[23:16]},
        '{16'h0003, CTRL_COMMON_WR, GW_IP[15:8]},
        '{16'h0004, CTRL_COMMON_WR, GW_IP[7:0]},
        '{16'h0005, CTRL_COMMON_WR, SUBNET[31:24]},
        '{16'h0006, CTRL_COMMON_WR, SUBNET[23:16]},
        '{16'h0007, CTRL_COMMON_WR, SUBNET[15:8]},
        '{16'h0008, CTRL_COMMON_WR, SUBNET[7:0]},
        // Socket 0 in UDP mode with an 8 KB TX buffer
        '{16'h0000, CTRL_S0_WR, 8'h02},
        '{16'h001F, CTRL_S0_WR, 8'h08},
        '{16'h0004, CTRL_S0_WR, SRC_PORT[15:8]},
        '{16'h0005, CTRL_S0_WR, SRC_PORT[7:0]},
        '{16'h000C, CTRL_S0_WR, DST_IP[31:24]},
        '{16'h000D, CTRL_S0_WR, DST_IP[23:16]},
        '{16'h000E, CTRL_S0_WR, DST_IP[15:8]},
        '{16'h000F, CTRL_S0_WR, DST_IP[7:0]},
        '{16'h0010, CTRL_S0_WR, DST_PORT[15:8]},
        '{16'h0011, CTRL_S0_WR, DST_PORT[7:0]},
        // OPEN
        '{16'h0001, CTRL_S0_WR, 8'h01}
    };

    seq_state_e        state;
    logic [4:0]        init_idx;
    logic [POLL_W-1:0] poll_cnt;
    logic              busy;
    logic [15:0]       rx_ptr;
    logic [15:0]       tx_ptr;

    // Request of the current state, sampled by the engine at frame_start
    always_comb begin
        frame_req.kind = FRAME_CMD;
        frame_req.cmd  = '{16'h0000, CTRL_S0_RD, 8'h00};
        case (state)
            INIT:        frame_req.cmd = INIT_TABLE[init_idx];
            WAIT_SOCKET: frame_req.cmd = '{16'h0003, CTRL_S0_RD, 8'h00};
            POLL:        frame_req.cmd = '{16'h0027, CTRL_S0_RD, 8'h00};
            PULL: begin
                frame_req.kind = FRAME_PULL;
                frame_req.cmd  = '{rx_ptr, CTRL_RXBUF_RD, 8'h00};
            end
            RX_PTR_HI:   frame_req.cmd = '{16'h0028, CTRL_S0_WR, rx_ptr[15:8]};
            RX_PTR_LO:   frame_req.cmd = '{16'h0029, CTRL_S0_WR, rx_ptr[7:0]};
            RX_RECV:     frame_req.cmd = '{16'h0001, CTRL_S0_WR, 8'h40};
            PUSH: begin
                frame_req.kind = FRAME_PUSH;
                frame_req.cmd  = '{tx_ptr, CTRL_TXBUF_WR, 8'h00};
            end
            TX_PTR_HI:   frame_req.cmd = '{16'h0024, CTRL_S0_WR, tx_ptr[15:8]};
            TX_PTR_LO:   frame_req.cmd = '{16'h0025, CTRL_S0_WR, tx_ptr[7:0]};
            TX_SEND:     frame_req.cmd = '{16'h0001, CTRL_S0_WR, 8'h20};
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        frame_start <= 1'b0;
        reply_taken <= 1'b0;
        if (reset) begin
            state    <= INIT;
            init_idx <= '0;
            poll_cnt <= '0;
            busy     <= 1'b0;
            rx_ptr   <= '0;
            tx_ptr   <= '0;
        end else if (frame_done) begin
            // most frames chain straight into the next one
            frame_start <= 1'b1;
            case (state)
                INIT: begin
                    if (init_idx == 5'(INIT_LEN - 1)) begin
                        state <= WAIT_SOCKET;
                    end else begin
                        init_idx <= init_idx + 5'd1;
                    end
                end
                WAIT_SOCKET: begin
                    if (read_byte == SOCK_UDP) begin
                        state       <= IDLE;
                        frame_start <= 1'b0;
                        busy        <= 1'b0;
                    end
                end
                POLL: begin
                    if (read_byte != 8'h00) begin
                        state <= PULL;
                    end else begin
                        state       <= IDLE;
                        frame_start <= 1'b0;
                        busy        <= 1'b0;
                    end
                end
                PULL: begin
                    rx_ptr <= rx_ptr + RX_STEP;
                    state  <= RX_PTR_HI;
                end
                RX_PTR_HI: state <= RX_PTR_LO;
                RX_PTR_LO: state <= RX_RECV;
                PUSH: begin
                    tx_ptr <= tx_ptr + TX_STEP;
                    state  <= TX_PTR_HI;
                end
                TX_PTR_HI: state <= TX_PTR_LO;
                TX_PTR_LO: state <= TX_SEND;
                // RECV and SEND end a sequence
                default: begin
                    state       <= IDLE;
                    frame_start <= 1'b0;
                    busy        <= 1'b0;
                end
            endcase
        end else if (!busy) begin
            case (state)
                INIT: begin
                    frame_start <= 1'b1;
                    busy        <= 1'b1;
                end
                IDLE: begin
                    if (reply_pending) begin
                        state       <= PUSH;
                        frame_start <= 1'b1;
                        busy        <= 1'b1;
                        reply_taken <= 1'b1;
                    end else if (poll_cnt == POLL_W'(`UDP_LINK_POLL_INTERVAL)) begin
                        poll_cnt    <= '0;
                        state       <= POLL;
                        frame_start <= 1'b1;
                        busy        <= 1'b1;
                    end else begin
                        poll_cnt <= poll_cnt + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== udp_rx_filter.sv ====
`include "udp_link_settings.svh"

module udp_rx_filter (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               frame_done,
    input  logic [udp_link_pkg::PULL_BITS-1:0] pull_bits,
    output udp_link_pkg::payload_t             rx_data,
    output logic                               rx_valid
);
    import udp_link_pkg::*;

    localparam int PAYLOAD_BITS = $bits(payload_t);

    payload_t payload;
    logic     id_match;

    // Header sits in front, payload in the low bits of the pulled frame
    assign payload  = pull_bits[PAYLOAD_BITS-1:0];
    assign id_match = (payload[PAYLOAD_BITS-1 -: 32] == `UDP_LINK_MSG_ID);

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= frame_done && id_match;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_done && id_match) begin
            rx_data <= payload;
        end
    end

endmodule

// ==== udp_reply_ctrl.sv ====
`include "udp_link_settings.svh"

module udp_reply_ctrl #(
    parameter int unsigned TIMEOUT_CYCLES = `UDP_LINK_TIMEOUT_CYCLES
) (
    input  logic clk,
    input  logic reset,
    input  logic rx_valid,
    input  logic reply_taken,
    output logic reply_pending,
    output logic pkg_timeout
);

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    logic [CNT_W-1:0] idle_cnt;

    // A datagram accepted while a reply waits merges into that reply
    always_ff @(posedge clk) begin
        if (reset) begin
            reply_pending <= 1'b0;
        end else if (rx_valid) begin
            reply_pending <= 1'b1;
        end else if (reply_taken) begin
            reply_pending <= 1'b0;
        end
    end

    // Saturates at the timeout count
    always_ff @(posedge clk) begin
        if (reset || rx_valid) begin
            idle_cnt <= '0;
        end else if (idle_cnt != CNT_W'(TIMEOUT_CYCLES)) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    assign pkg_timeout = (idle_cnt == CNT_W'(TIMEOUT_CYCLES));

endmodule

// ==== w5500_udp_link.sv ====
`include "udp_link_settings.svh"

module w5500_udp_link #(
    parameter int unsigned TIMEOUT_CYCLES = `UDP_LINK_TIMEOUT_CYCLES
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   miso,
    output logic                   mosi,
    output logic                   sclk,
    output logic                   cs_n,
    input  udp_link_pkg::payload_t tx_data,
    output udp_link_pkg::payload_t rx_data,
    output logic                   rx_valid,
    output logic                   pkg_timeout
);
    import udp_link_pkg::*;

    frame_req_t           frame_req;
    logic                 frame_start;
    logic                 frame_done;
    logic [7:0]           read_byte;
    logic [PULL_BITS-1:0] pull_bits;
    logic                 pull_done;
    logic                 reply_pending;
    logic                 reply_taken;

    w5500_cmd_sequencer sequencer_i (
        .clk           (clk),
        .reset         (reset),
        .frame_req     (frame_req),
        .frame_start   (frame_start),
        .frame_done    (frame_done),
        .read_byte     (read_byte),
        .reply_pending (reply_pending),
        .reply_taken   (reply_taken)
    );

    w5500_spi_engine spi_engine_i (
        .clk         (clk),
        .reset       (reset),
        .frame_req   (frame_req),
        .frame_start (frame_start),
        .tx_data     (tx_data),
        .miso        (miso),
        .frame_done  (frame_done),
        .read_byte   (read_byte),
        .pull_bits   (pull_bits),
        .mosi        (mosi),
        .sclk        (sclk),
        .cs_n        (cs_n)
    );

    // Request still shows the pull while its frame_done is high
    assign pull_done = frame_done && (frame_req.kind == FRAME_PULL);

    udp_rx_filter rx_filter_i (
        .clk        (clk),
        .reset      (reset),
        .frame_done (pull_done),
        .pull_bits  (pull_bits),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid)
    );

    udp_reply_ctrl #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) reply_ctrl_i (
        .clk           (clk),
        .reset         (reset),
        .rx_valid      (rx_valid),
        .reply_taken   (reply_taken),
        .reply_pending (reply_pending),
        .pkg_timeout   (pkg_timeout)
    );

endmodule

// ==== w5500_spi_model.sv ====
module w5500_spi_model (
    input  logic                               clk,
    input  logic                               sclk,
    input  logic                               cs_n,
    input  logic                               mosi,
    output logic                               miso,
    input  logic                               inject,
    input  logic [udp_link_pkg::PULL_BITS-1:0] inject_frame,
    output logic                               wr_valid,
    output udp_link_pkg::spi_cmd_t             wr_cmd,
    output logic                               sock_open
);
    timeunit 1ns;
    timeprecision 1ps;
    import udp_link_pkg::*;

    localparam int DGRAM_BYTES = PULL_BITS / 8;

    logic [7:0]  sock_reg [64];
    logic [7:0]  rx_buf [2048];
    logic [15:0] rx_wr;
    logic [15:0] rx_rd;
    logic        opened;
    int          sr_reads;
    int          bit_cnt;
    logic [23:0] hdr;
    logic [7:0]  in_byte;
    logic [7:0]  out_byte;

    initial begin
        rx_wr     = '0;
        rx_rd     = '0;
        opened    = 1'b0;
        sr_reads  = 0;
        bit_cnt   = 0;
        miso      = 1'b0;
        wr_valid  = 1'b0;
        wr_cmd    = '0;
        sock_open = 1'b0;
        foreach (sock_reg[i]) begin
            sock_reg[i] = '0;
        end
    end

    // Sn_SR reports UDP a few reads after OPEN, Sn_RX_RSR follows the pointers
    task automatic load_read(input logic [15:0] addr);
        logic [15:0] rx_size;
        rx_size = rx_wr - rx_rd;
        if (hdr[7:3] == 5'd3) begin
            out_byte = rx_buf[addr[10:0]];
        end else if (addr == 16'h0003) begin
            sr_reads++;
            out_byte = (opened && sr_reads > 2) ? SOCK_UDP : 8'h00;
            sock_open <= opened && sr_reads > 2;
        end else if (addr == 16'h0027) begin
            out_byte = rx_size[7:0];
        end else begin
            out_byte = sock_reg[addr[5:0]];
        end
    endtask

    task automatic store_write(input logic [15:0] addr, input logic [7:0] data);
        wr_cmd   <= '{addr, hdr[7:0], data};
        wr_valid <= 1'b1;
        if (hdr[7:3] == 5'd1) begin
            sock_reg[addr[5:0]] = data;
            // OPEN and RECV commands on Sn_CR
            if (addr == 16'h0001 && data == 8'h01) begin
                opened = 1'b1;
            end
            if (addr == 16'h0001 && data == 8'h40) begin
                rx_rd = {sock_reg[6'h28], sock_reg[6'h29]};
            end
        end
    endtask

    always @(negedge cs_n) begin
        bit_cnt = 0;
    end

    always @(posedge sclk) begin
        if (!cs_n) begin
            if (bit_cnt < 24) begin
                hdr = {hdr[22:0], mosi};
            end else begin
                in_byte = {in_byte[6:0], mosi};
            end
            bit_cnt++;
            if (bit_cnt >= 24 && bit_cnt % 8 == 0) begin
                if (!hdr[2]) begin
                    load_read(hdr[23:8] + 16'((bit_cnt - 24) / 8));
                end else if (bit_cnt > 24) begin
                    store_write(hdr[23:8] + 16'((bit_cnt - 32) / 8), in_byte);
                end
            end
        end
    end

    always @(negedge sclk) begin
        wr_valid <= 1'b0;
        if (bit_cnt >= 24) begin
            miso <= out_byte[7 - (bit_cnt % 8)];
        end
    end

    // A whole datagram lands in the RX buffer in one step
    always @(posedge clk) begin
        if (inject) begin
            for (int i = 0; i < DGRAM_BYTES; i++) begin
                rx_buf[11'(rx_wr + 16'(i))] = inject_frame[PULL_BITS-1-8*i -: 8];
            end
            rx_wr = rx_wr + 16'(DGRAM_BYTES);
        end
    end

endmodule

// ==== w5500_udp_link_asserts.sv ====
module w5500_udp_link_asserts (
    input logic clk,
    input logic reset,
    input logic cs_n,
    input logic sclk,
    input logic frame_done
);
    timeunit 1ns;
    timeprecision 1ps;

    // Clock pulses only while the W5500 is selected
    cs_low_in_frame: assert property (
        @(posedge clk) disable iff (reset) sclk |-> !cs_n
    ) else $error("sclk high while cs_n is high");

    // Mode 0 starts low at selection and the first edge rises
    sclk_low_at_select: assert property (
        @(posedge clk) disable iff (reset) $fell(cs_n) |=> $rose(sclk)
    ) else $error("sclk not low then rising after cs_n fell");

    done_single_pulse: assert property (
        @(posedge clk) disable iff (reset) frame_done |=> !frame_done
    ) else $error("frame_done high for more than one cycle");

endmodule

bind w5500_spi_engine w5500_udp_link_asserts asserts_i (
    .clk        (clk),
    .reset      (reset),
    .cs_n       (cs_n),
    .sclk       (sclk),
    .frame_done (frame_done)
);

// ==== w5500_udp_link_tb.sv ====
`include "udp_link_settings.svh"

module w5500_udp_link_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import udp_link_pkg::*;

    localparam int unsigned TIMEOUT_CYCLES = 20000;
    localparam int STEP_LIMIT = 5000;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 miso;
    logic                 mosi;
    logic                 sclk;
    logic                 cs_n;
    payload_t             tx_data;
    payload_t             rx_data;
    logic                 rx_valid;
    logic                 pkg_timeout;
    logic                 inject;
    logic [PULL_BITS-1:0] inject_frame;
    logic                 wr_valid;
    spi_cmd_t             wr_cmd;
    logic                 sock_open;

    spi_cmd_t    exp_wr[$];
    payload_t    exp_rx[$];
    logic [15:0] rx_ptr;
    logic [15:0] tx_ptr;
    int unsigned cycle = 0;
    int unsigned last_rx_cycle;

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    w5500_udp_link #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) w5500_udp_link_i (.*);

    w5500_spi_model spi_model_i (.*);

    // Accepted when the top payload word carries the message ID
    function automatic bit expected_rx(input payload_t payload, output payload_t data);
        data = payload;
        return payload[$bits(payload_t)-1 -: 32] == `UDP_LINK_MSG_ID;
    endfunction

    task automatic abort_run(input string reason);
        $display("Error: %s", reason);
        $display("TB FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_payload(input string name, input payload_t got, input payload_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            $display("TB FAILED");
            $fatal(1, "payload mismatch");
        end
    endtask

    task automatic check_reg_write(input string name, input spi_cmd_t got, input spi_cmd_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            $display("TB FAILED");
            $fatal(1, "register write mismatch");
        end
    endtask

    // Multi-byte values go out MSB first at rising addresses
    task automatic expect_bytes(input logic [7:0] ctrl, input logic [15:0] addr,
                                input logic [63:0] value, input int n);
        for (int i = 0; i < n; i++) begin
            exp_wr.push_back(spi_cmd_t'{addr + 16'(i), ctrl, value[8*(n-1-i) +: 8]});
        end
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while ((exp_wr.size() != 0 || exp_rx.size() != 0) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (exp_wr.size() != 0 || exp_rx.size() != 0) begin
            abort_run("expected W5500 traffic did not arrive in time");
        end
    endtask

    task automatic send_datagram(input payload_t payload);
        payload_t   data;
        rx_header_t hdr;
        hdr = '{$urandom(), 16'($urandom()), 16'($bits(payload_t) / 8)};
        @(negedge clk);
        tx_data = {$urandom(), $urandom()};
        // Info header and payload both leave the RX buffer
        rx_ptr  = rx_ptr + 16'($bits(rx_header_t) / 8 + $bits(payload_t) / 8);
        expect_bytes(CTRL_S0_WR, 16'h0028, rx_ptr, 2);
        expect_bytes(CTRL_S0_WR, 16'h0001, 8'h40, 1);
        if (expected_rx(payload, data)) begin
            exp_rx.push_back(data);
            expect_bytes(CTRL_TXBUF_WR, tx_ptr, tx_data, $bits(payload_t) / 8);
            tx_ptr = tx_ptr + 16'($bits(payload_t) / 8);
            expect_bytes(CTRL_S0_WR, 16'h0024, tx_ptr, 2);
            expect_bytes(CTRL_S0_WR, 16'h0001, 8'h20, 1);
        end
        inject       = 1'b1;
        inject_frame = {hdr, payload};
        @(negedge clk);
        inject = 1'b0;
        wait_drained(STEP_LIMIT);
    endtask

    always @(negedge clk) begin
        if (wr_valid) begin
            if (exp_wr.size() == 0) begin
                abort_run($sformatf("unexpected register write 0x%h", wr_cmd));
            end else begin
                check_reg_write("wr_cmd", wr_cmd, exp_wr.pop_front());
            end
        end
        if (rx_valid) begin
            last_rx_cycle = cycle;
            if (exp_rx.size() == 0) begin
                abort_run("rx_valid without an accepted datagram");
            end else begin
                check_payload("rx_data", rx_data, exp_rx.pop_front());
            end
        end
    end

    initial begin
        int n;
        void'($urandom(32'h6ea2b3e9));
        reset         = 1'b1;
        tx_data       = '0;
        inject        = 1'b0;
        inject_frame  = '0;
        rx_ptr        = '0;
        tx_ptr        = '0;
        last_rx_cycle = 0;

        expect_bytes(CTRL_COMMON_WR, 16'h002E, 8'hD8, 1);
        expect_bytes(CTRL_COMMON_WR, 16'h0009, `UDP_LINK_MAC_ADDR, 6);
        expect_bytes(CTRL_COMMON_WR, 16'h000F, `UDP_LINK_LOCAL_IP, 4);
        expect_bytes(CTRL_COMMON_WR, 16'h0001, `UDP_LINK_GATEWAY_IP, 4);
        expect_bytes(CTRL_COMMON_WR, 16'h0005, `UDP_LINK_SUBNET_MASK, 4);
        expect_bytes(CTRL_S0_WR, 16'h0000, 8'h02, 1);
        expect_bytes(CTRL_S0_WR, 16'h001F, 8'h08, 1);
        expect_bytes(CTRL_S0_WR, 16'h0004, `UDP_LINK_LOCAL_PORT, 2);
        expect_bytes(CTRL_S0_WR, 16'h000C, `UDP_LINK_DST_IP, 4);
        expect_bytes(CTRL_S0_WR, 16'h0010, `UDP_LINK_DST_PORT, 2);
        expect_bytes(CTRL_S0_WR, 16'h0001, 8'h01, 1);

        repeat (4) @(negedge clk);
        reset = 1'b0;
        wait_drained(STEP_LIMIT);

        n = 0;
        while (!sock_open && n < STEP_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!sock_open) begin
            abort_run("socket status never reported UDP");
        end
        if (pkg_timeout) begin
            abort_run("pkg_timeout high right after initialization");
        end

        send_datagram({`UDP_LINK_MSG_ID, $urandom()});
        send_datagram({`UDP_LINK_MSG_ID ^ ($urandom() | 32'h1), $urandom()});
        send_datagram({`UDP_LINK_MSG_ID, $urandom()});

        // Only polls from here on, so the timeout must fire
        n = 0;
        while (!pkg_timeout && n < TIMEOUT_CYCLES + 100) begin
            @(negedge clk);
            n++;
        end
        if (!pkg_timeout) begin
            abort_run("pkg_timeout did not rise");
        end else if (cycle - last_rx_cycle < TIMEOUT_CYCLES
                     || cycle - last_rx_cycle > TIMEOUT_CYCLES + 2) begin
            abort_run("pkg_timeout rose at the wrong time");
        end

        send_datagram({`UDP_LINK_MSG_ID, $urandom()});
        if (pkg_timeout) begin
            abort_run("pkg_timeout still high after an accepted datagram");
        end

        if (exp_wr.size() == 0 && exp_rx.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abort_run("expected traffic left over at the end of the run");
        end
    end

endmodule

// ==== w5500_udp_link.f ====
+incdir+.
udp_link_pkg.sv
w5500_spi_engine.sv
w5500_cmd_sequencer.sv
udp_rx_filter.sv
udp_reply_ctrl.sv
w5500_udp_link.sv
w5500_spi_model.sv
w5500_udp_link_asserts.sv
w5500_udp_link_tb.sv

// ==== Bender.yml ====
package:
  name: w5500_udp_link

export_include_dirs:
  - .

sources:
  - udp_link_pkg.sv
  - w5500_spi_engine.sv
  - w5500_cmd_sequencer.sv
  - udp_rx_filter.sv
  - udp_reply_ctrl.sv
  - w5500_udp_link.sv
  - target: test
    files:
      - w5500_spi_model.sv
      - w5500_udp_link_asserts.sv
      - w5500_udp_link_tb.sv
